//--- common/l2_mem_macros.svh
/*
 * L2 memory map and sizing
 * Bank count, bank depths and region base addresses of the shared L2,
 * used by the crossbar decoder, the bank array and the testbench
 */
`ifndef L2_MEM_MACROS_SVH
`define L2_MEM_MACROS_SVH

// Interleaved region, consecutive words rotate across the banks
`define L2_NB_BANKS        4
`define L2_INTL_BANK_WORDS 1024

// Private banks, one contiguous window each
`define L2_PRI_BANK_WORDS  512

// Region bases, byte addresses
`define L2_PRI0_BASE       32'h1C00_0000
`define L2_PRI1_BASE       32'h1C00_8000
`define L2_INTL_BASE       32'h1C01_0000

// Region spans in bytes
`define L2_PRI_SPAN        (`L2_PRI_BANK_WORDS * 4)
`define L2_INTL_SPAN       (`L2_NB_BANKS * `L2_INTL_BANK_WORDS * 4)

`define L2_NB_MASTERS      2

`endif

//--- common/l2_mem_pkg.sv
/*
 * L2 memory subsystem types
 * Master request and response, bank port request and target index
 */
`default_nettype none

package l2_mem_pkg;

   // Four interleaved banks plus two private banks
   parameter int unsigned NumTargets = 6;

   // Target numbering, interleaved banks take 0 to 3
   parameter int unsigned TgtPri0 = 4;
   parameter int unsigned TgtPri1 = 5;

   typedef logic [2:0] target_t;

   // Request from a bus master, held until ready
   typedef struct packed {
      logic        valid;
      logic [31:0] addr;
      logic        we;
      logic [3:0]  be;
      logic [31:0] wdata;
   } mem_req_t;

   // Response, always accepted by the master
   typedef struct packed {
      logic        valid;
      logic [31:0] rdata;
      logic        err;
   } mem_rsp_t;

   // One bank port, full byte address still attached
   typedef struct packed {
      logic        req;
      logic [31:0] addr;
      logic        we;
      logic [3:0]  be;
      logic [31:0] wdata;
   } bank_req_t;

endpackage

`default_nettype wire

//--- logic/l2_rr_arbiter.sv
/*
 * Two-requester round-robin arbiter
 * Lone requester wins directly, a tie goes to the pointed master
 * and the pointer then moves to the other one
 */
`timescale 1ns/1ps
`default_nettype none

module l2_rr_arbiter (
   input  logic       clk_i,
   input  logic       rst_ni,
   input  logic [1:0] req_i,
   output logic [1:0] gnt_o
);

   // Priority pointer
   // Low means master 0 wins a tie
   logic prio_q;

   // Grant is combinational and lands in the same cycle as the request
   always_comb begin
      if (&req_i) begin
         gnt_o = prio_q ? 2'b10 : 2'b01;
      end else begin
         // Zero or one requester
         gnt_o = req_i;
      end
   end

   // Move pointer only on a contested grant
   // A granted request is always taken since ready is the grant
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         prio_q <= 1'b0;
      end else if (&req_i) begin
         prio_q <= ~prio_q;
      end
   end

   // At most one winner and never an idle master
   a_gnt_valid: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      $onehot0(gnt_o) && ((gnt_o & ~req_i) == 2'b00)
   ) else $error("bad grant %b for request %b", gnt_o, req_i);

endmodule

`default_nettype wire

//--- l2_ram/l2_ram_bank.sv
/*
 * L2 SRAM bank
 * Behavioral single-port word array with per-byte write enables
 * and a registered read port
 */
`timescale 1ns/1ps
`default_nettype none

module l2_ram_bank #(
   parameter int unsigned NumWords = 1024,
   localparam int unsigned AddrW = $clog2(NumWords)
) (
   input  logic             clk_i,
   input  logic             rst_ni,
   input  logic             req_i,
   input  logic             we_i,
   input  logic [AddrW-1:0] addr_i,
   input  logic [31:0]      wdata_i,
   input  logic [3:0]       be_i,
   output logic [31:0]      rdata_o
);

   // Storage array
   logic [31:0] mem_q [NumWords];

   // Write port
   // Only lanes with their enable set are touched
   always_ff @(posedge clk_i) begin
      if (req_i && we_i) begin
         for (int b = 0; b < 4; b++) begin
            if (be_i[b]) begin
               mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
            end
         end
      end
   end

   // Read port
   // Word lands in rdata_o on the edge that takes the request
   // Holds its last value on writes and idle cycles
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         rdata_o <= '0;
      end else if (req_i && !we_i) begin
         rdata_o <= mem_q[addr_i];
      end
   end

endmodule

`default_nettype wire

//--- l2_ram/l2_ram_multi_bank.sv
/*
 * L2 bank array
 * Four interleaved banks and two private banks behind six bank ports
 * Every port grants at once and answers exactly one cycle later
 * Region base is removed before the word address is cut out
 */
`timescale 1ns/1ps
`default_nettype none
`include "l2_mem_macros.svh"

module l2_ram_multi_bank
   import l2_mem_pkg::*;
(
   input  logic                  clk_i,
   input  logic                  rst_ni,
   input  bank_req_t             bank_req_i    [NumTargets],
   output logic [31:0]           bank_rdata_o  [NumTargets],
   output logic [NumTargets-1:0] bank_rvalid_o
);

   // Word address widths
   localparam int unsigned IntlAw   = $clog2(`L2_INTL_BANK_WORDS);
   localparam int unsigned PriAw    = $clog2(`L2_PRI_BANK_WORDS);
   localparam int unsigned BankSelW = $clog2(`L2_NB_BANKS);

   // Fixed one-cycle response on every port
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         bank_rvalid_o <= '0;
      end else begin
         for (int t = 0; t < NumTargets; t++) begin
            bank_rvalid_o[t] <= bank_req_i[t].req;
         end
      end
   end

   // Interleaved banks
   logic [31:0] intl_off [`L2_NB_BANKS];

   for (genvar i = 0; i < `L2_NB_BANKS; i++) begin : g_intl
      // Offset into the interleaved region
      assign intl_off[i] = bank_req_i[i].addr - `L2_INTL_BASE;

      // Byte bits and bank-select bits dropped
      l2_ram_bank #(
         .NumWords(`L2_INTL_BANK_WORDS)
      ) i_bank (
         .clk_i,
         .rst_ni,
         .req_i  (bank_req_i[i].req),
         .we_i   (bank_req_i[i].we),
         .addr_i (intl_off[i][IntlAw+2+BankSelW-1:2+BankSelW]),
         .wdata_i(bank_req_i[i].wdata),
         .be_i   (bank_req_i[i].be),
         .rdata_o(bank_rdata_o[i])
      );

      // Crossbar must only send this bank its own words of the region
      a_intl_in_bank: assert property (
         @(posedge clk_i) disable iff (!rst_ni)
         bank_req_i[i].req |->
            (intl_off[i] < `L2_INTL_SPAN) &&
            (intl_off[i][2 +: BankSelW] == BankSelW'(i))
      ) else $error("interleaved bank %0d got foreign address %h", i, bank_req_i[i].addr);
   end

   // Private banks
   logic [31:0] pri_off [2];

   for (genvar p = 0; p < 2; p++) begin : g_pri
      localparam int unsigned T = TgtPri0 + p;
      localparam logic [31:0] Base = (p == 0) ? `L2_PRI0_BASE : `L2_PRI1_BASE;

      assign pri_off[p] = bank_req_i[T].addr - Base;

      // Contiguous window, only the byte bits go
      l2_ram_bank #(
         .NumWords(`L2_PRI_BANK_WORDS)
      ) i_bank (
         .clk_i,
         .rst_ni,
         .req_i  (bank_req_i[T].req),
         .we_i   (bank_req_i[T].we),
         .addr_i (pri_off[p][PriAw+1:2]),
         .wdata_i(bank_req_i[T].wdata),
         .be_i   (bank_req_i[T].be),
         .rdata_o(bank_rdata_o[T])
      );

      // Decoded address stays within this private window
      a_pri_in_bank: assert property (
         @(posedge clk_i) disable iff (!rst_ni)
         bank_req_i[T].req |-> (pri_off[p] < `L2_PRI_SPAN)
      ) else $error("private bank %0d got foreign address %h", p, bank_req_i[T].addr);
   end

endmodule

`default_nettype wire

//--- logic/l2_xbar.sv
/*
 * L2 crossbar
 * Decodes each master address to a bank, arbitrates per bank,
 * routes the winner's request and steers the bank answer back
 * Unmapped addresses are taken at once and answered with err
 */
`timescale 1ns/1ps
`default_nettype none
`include "l2_mem_macros.svh"

module l2_xbar
   import l2_mem_pkg::*;
(
   input  logic                      clk_i,
   input  logic                      rst_ni,
   input  mem_req_t                  mst_req_i     [`L2_NB_MASTERS],
   output logic [`L2_NB_MASTERS-1:0] mst_ready_o,
   output mem_rsp_t                  mst_rsp_o     [`L2_NB_MASTERS],
   output bank_req_t                 bank_req_o    [NumTargets],
   input  logic [31:0]               bank_rdata_i  [NumTargets],
   input  logic [NumTargets-1:0]     bank_rvalid_i
);

   localparam int unsigned BankSelW = $clog2(`L2_NB_BANKS);

   // Decode results per master
   target_t                   tgt     [`L2_NB_MASTERS];
   logic [`L2_NB_MASTERS-1:0] dec_err;
   logic [`L2_NB_MASTERS-1:0] acc;

   // Per-target request and grant, bit m is master m
   logic [1:0] tgt_req [NumTargets];
   logic [1:0] tgt_gnt [NumTargets];

   // State for the response one cycle after acceptance
   logic [`L2_NB_MASTERS-1:0] pend_q;
   logic [`L2_NB_MASTERS-1:0] err_q;
   logic [`L2_NB_MASTERS-1:0] we_q;
   target_t                   tgt_q   [`L2_NB_MASTERS];

   // Address decode
   for (genvar m = 0; m < `L2_NB_MASTERS; m++) begin : g_dec
      logic [31:0] pri0_off;
      logic [31:0] pri1_off;
      logic [31:0] intl_off;
      target_t     tgt_d;
      logic        err_d;

      // Wrap-around makes addresses below a base fail the compare
      assign pri0_off = mst_req_i[m].addr - `L2_PRI0_BASE;
      assign pri1_off = mst_req_i[m].addr - `L2_PRI1_BASE;
      assign intl_off = mst_req_i[m].addr - `L2_INTL_BASE;

      always_comb begin
         err_d = 1'b0;
         if (pri0_off < `L2_PRI_SPAN) begin
            tgt_d = target_t'(TgtPri0);
         end else if (pri1_off < `L2_PRI_SPAN) begin
            tgt_d = target_t'(TgtPri1);
         end else if (intl_off < `L2_INTL_SPAN) begin
            // Word bits above the byte offset pick the bank
            tgt_d = target_t'(mst_req_i[m].addr[2 +: BankSelW]);
         end else begin
            tgt_d = '0;
            err_d = 1'b1;
         end
      end

      assign tgt[m]     = tgt_d;
      assign dec_err[m] = err_d;
   end

   // Requests per target, decode errors never reach a bank
   always_comb begin
      for (int t = 0; t < NumTargets; t++) begin
         for (int m = 0; m < `L2_NB_MASTERS; m++) begin
            tgt_req[t][m] = mst_req_i[m].valid && !dec_err[m] && (tgt[m] == target_t'(t));
         end
      end
   end

   // One arbiter per bank
   for (genvar t = 0; t < NumTargets; t++) begin : g_arb
      l2_rr_arbiter i_arb (
         .clk_i,
         .rst_ni,
         .req_i(tgt_req[t]),
         .gnt_o(tgt_gnt[t])
      );

      a_single_owner: assert property (
         @(posedge clk_i) disable iff (!rst_ni)
         !(&tgt_gnt[t])
      ) else $error("target %0d granted to both masters", t);
   end

   // Forward the winning master to each bank
   always_comb begin
      for (int t = 0; t < NumTargets; t++) begin
         bank_req_o[t].req   = |tgt_gnt[t];
         bank_req_o[t].addr  = mst_req_i[tgt_gnt[t][1]].addr;
         bank_req_o[t].we    = mst_req_i[tgt_gnt[t][1]].we;
         bank_req_o[t].be    = mst_req_i[tgt_gnt[t][1]].be;
         bank_req_o[t].wdata = mst_req_i[tgt_gnt[t][1]].wdata;
      end
   end

   // Ready is the grant, banks never stall
   always_comb begin
      for (int m = 0; m < `L2_NB_MASTERS; m++) begin
         mst_ready_o[m] = dec_err[m];
         for (int t = 0; t < NumTargets; t++) begin
            mst_ready_o[m] = mst_ready_o[m] | tgt_gnt[t][m];
         end
         acc[m] = mst_req_i[m].valid & mst_ready_o[m];
      end
   end

   // Response control
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         pend_q <= '0;
         err_q  <= '0;
      end else begin
         pend_q <= acc & ~dec_err;
         err_q  <= acc & dec_err;
      end
   end

   // Steering info for the returning word
   always_ff @(posedge clk_i) begin
      for (int m = 0; m < `L2_NB_MASTERS; m++) begin
         if (acc[m]) begin
            tgt_q[m] <= tgt[m];
            we_q[m]  <= mst_req_i[m].we;
         end
      end
   end

   // Writes and errors come back with zero data
   always_comb begin
      for (int m = 0; m < `L2_NB_MASTERS; m++) begin
         mst_rsp_o[m].valid = err_q[m] | (pend_q[m] & bank_rvalid_i[tgt_q[m]]);
         mst_rsp_o[m].err   = err_q[m];
         mst_rsp_o[m].rdata = (pend_q[m] & ~we_q[m]) ? bank_rdata_i[tgt_q[m]] : '0;
      end
   end

   // Every accepted request is answered on the next cycle
   for (genvar m = 0; m < `L2_NB_MASTERS; m++) begin : g_lat
      a_rsp_latency: assert property (
         @(posedge clk_i) disable iff (!rst_ni)
         acc[m] |=> mst_rsp_o[m].valid
      ) else $error("master %0d response missing one cycle after accept", m);
   end

endmodule

`default_nettype wire

//--- logic/l2_subsystem.sv
/*
 * L2 memory subsystem top
 * Two masters reach six SRAM banks through the crossbar
 */
`timescale 1ns/1ps
`default_nettype none
`include "l2_mem_macros.svh"

module l2_subsystem
   import l2_mem_pkg::*;
(
   input  logic                      clk_i,
   input  logic                      rst_ni,
   input  mem_req_t                  mst_req_i   [`L2_NB_MASTERS],
   output logic [`L2_NB_MASTERS-1:0] mst_ready_o,
   output mem_rsp_t                  mst_rsp_o   [`L2_NB_MASTERS]
);

   // Crossbar to bank array
   bank_req_t             bank_req    [NumTargets];
   logic [31:0]           bank_rdata  [NumTargets];
   logic [NumTargets-1:0] bank_rvalid;

   l2_xbar i_xbar (
      .clk_i,
      .rst_ni,
      .mst_req_i,
      .mst_ready_o,
      .mst_rsp_o,
      .bank_req_o   (bank_req),
      .bank_rdata_i (bank_rdata),
      .bank_rvalid_i(bank_rvalid)
   );

   l2_ram_multi_bank i_banks (
      .clk_i,
      .rst_ni,
      .bank_req_i   (bank_req),
      .bank_rdata_o (bank_rdata),
      .bank_rvalid_o(bank_rvalid)
   );

endmodule

`default_nettype wire

//--- dv/tb_l2_stim.svh
/*
 * L2 testbench stimulus table
 * One row per master request, rows marked pair go out together with the next row
 */
`ifndef TB_L2_STIM_SVH
`define TB_L2_STIM_SVH

// Columns: pair, clash, mst, we, rnd, err, addr, be, wdata
// clash expects a single ready in the first cycle of a pair
// rnd replaces wdata with the next LCG value, err is the expected decode error
typedef struct packed {
   logic        pair;
   logic        clash;
   logic        mst;
   logic        we;
   logic        rnd;
   logic        err;
   logic [31:0] addr;
   logic [3:0]  be;
   logic [31:0] wdata;
} stim_t;

localparam int NumStim = 38;

localparam stim_t StimTab [NumStim] = '{
   // Private banks, first and last word, written by one master and read by the other
   '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 32'h1C00_0000, 4'hF, 32'hA5A5_0001},
   '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 32'h1C00_07FC, 4'hF, 32'hA5A5_0002},
   '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 32'h1C00_8000, 4'hF, 32'h5A5A_0003},
   '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 32'h1C00_87FC, 4'hF, 32'h5A5A_0004},
   '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 32'h1C00_0000, 4'h0, 32'h0},
   '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 32'h1C00_07FC, 4'h0, 32'h0},
   '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h1C00_8000, 4'h0, 32'h0},
   '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h1C00_87FC, 4'h0, 32'h0},
   // Interleaved sweep, five words wrap back to bank 0, plus the last word
   '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 32'h1C01_0000, 4'hF, 32'h0},
   '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 32'h1C01_0004, 4'hF, 32'h0},
   '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 32'h1C01_0008, 4'hF, 32'h0},
   '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 32'h1C01_000C, 4'hF, 32'h0},
   '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 32'h1C01_0010, 4'hF, 32'h0},
   '{1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 32'h1C01_3FFC, 4'hF, 32'h0},
   '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 32'h1C01_0000, 4'h0, 32'h0},
   '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 32'h1C01_0004, 4'h0, 32'h0},
   '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 32'h1C01_0008, 4'h0, 32'h0},
   '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 32'h1C01_000C, 4'h0, 32'h0},
   '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 32'h1C01_0010, 4'h0, 32'h0},
   '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h1C01_3FFC, 4'h0, 32'h0},
   // Partial writes, lanes merge into the previous word
   '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 32'h1C00_0100, 4'hF, 32'h1122_3344},
   '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 32'h1C00_0100, 4'h5, 32'hAABB_CCDD},
   '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 32'h1C00_0100, 4'h8, 32'hEE00_0000},
   '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 32'h1C00_0100, 4'h0, 32'h0},
   '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 32'h1C01_0008, 4'h6, 32'h1234_5678},
   '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h1C01_0008, 4'h0, 32'h0},
   // Both masters on interleaved bank 1
   '{1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 32'h1C01_0024, 4'hF, 32'h0BAD_0024},
   '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 32'h1C01_0044, 4'hF, 32'h0BAD_0044},
   '{1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 32'h1C01_0044, 4'h0, 32'h0},
   '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 32'h1C01_0024, 4'h0, 32'h0},
   // Different banks in the same cycle
   '{1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 32'h1C00_0004, 4'hF, 32'h7777_0004},
   '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 32'h1C01_0010, 4'hF, 32'h8888_0010},
   '{1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 32'h1C00_0004, 4'h0, 32'h0},
   '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h1C01_0010, 4'h0, 32'h0},
   // Unmapped, below private 0, both gaps and above the interleaved region
   '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 32'h1BFF_FFFC, 4'h0, 32'h0},
   '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 32'h1C00_0800, 4'hF, 32'hDEAD_0800},
   '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 32'h1C00_C000, 4'h0, 32'h0},
   '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 32'h1C01_4000, 4'h0, 32'h0}
};

`endif

//--- dv/tb_l2_subsystem.sv
/*
 * L2 memory subsystem testbench
 * Applies the stimulus table to both masters, keeps a reference memory
 * with the byte-lane merge rule and checks each response one cycle
 * after its acceptance
 */
`timescale 1ns/1ps
`default_nettype none
`include "l2_mem_macros.svh"

module tb_l2_subsystem
   import l2_mem_pkg::*;
();

   localparam int ClkPeriod   = 40;
   localparam int ResetCycles = 16;

`include "tb_l2_stim.svh"

   // Each row needs only a few cycles
   localparam int MaxCycles = 20 * NumStim + ResetCycles;

   logic                      clk_i;
   logic                      rst_ni;
   mem_req_t                  mst_req   [`L2_NB_MASTERS];
   logic [`L2_NB_MASTERS-1:0] mst_ready;
   mem_rsp_t                  mst_rsp   [`L2_NB_MASTERS];

   int errors;
   int checks;
   int cycles;

   logic [31:0] lcg_state;

   // Reference memory keyed by word address
   logic [31:0] ref_mem [logic [29:0]];

   l2_subsystem DUT (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .mst_req_i  (mst_req),
      .mst_ready_o(mst_ready),
      .mst_rsp_o  (mst_rsp)
   );

   initial begin
      clk_i = 1'b0;
      forever #(ClkPeriod / 2) clk_i = ~clk_i;
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Applies an accepted request to the model and returns the expected rdata
   function automatic logic [31:0] model_access(input mem_req_t req, input logic err);
      logic [29:0] key;
      logic [31:0] word;
      key  = req.addr[31:2];
      word = ref_mem.exists(key) ? ref_mem[key] : 32'h0;
      // Unmapped requests touch no memory
      if (err) begin
         return 32'h0;
      end
      if (req.we) begin
         for (int b = 0; b < 4; b++) begin
            if (req.be[b]) begin
               word[8*b +: 8] = req.wdata[8*b +: 8];
            end
         end
         ref_mem[key] = word;
         return 32'h0;
      end
      return word;
   endfunction

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
      end
   endtask

   // Drives rows first..last together and waits until all are answered
   task automatic run_step(input int first, input int last);
      logic [1:0]  pend;
      logic [1:0]  acc;
      logic [31:0] exp_rdata [2];
      logic        exp_err [2];
      bit          first_cycle;
      int          m;
      pend = 2'b00;
      for (int e = first; e <= last; e++) begin
         m = int'(StimTab[e].mst);
         mst_req[m].valid = 1'b1;
         mst_req[m].addr  = StimTab[e].addr;
         mst_req[m].we    = StimTab[e].we;
         mst_req[m].be    = StimTab[e].be;
         mst_req[m].wdata = StimTab[e].rnd ? lcg_next() : StimTab[e].wdata;
         exp_err[m]       = StimTab[e].err;
         pend[m]          = 1'b1;
      end
      first_cycle = 1'b1;
      while (pend != 2'b00) begin
         // Ready has settled on the new inputs by mid low phase
         #(ClkPeriod / 4);
         acc = pend & mst_ready;
         if (first_cycle) begin
            check_eq("mst_ready_o count", $countones(acc),
                     StimTab[first].clash ? 1 : $countones(pend));
            first_cycle = 1'b0;
         end
         for (m = 0; m < 2; m++) begin
            if (acc[m]) begin
               exp_rdata[m] = model_access(mst_req[m], exp_err[m]);
            end
         end
         // Response is stable once the acceptance edge has passed
         @(negedge clk_i);
         for (m = 0; m < 2; m++) begin
            if (mst_rsp[m].valid !== acc[m]) begin
               errors++;
               if (acc[m]) begin
                  $display("Master %0d got no response one cycle after acceptance", m);
               end else begin
                  $display("Master %0d got a response with no request accepted", m);
               end
            end else if (acc[m]) begin
               check_eq($sformatf("mst_rsp_o[%0d].rdata", m), mst_rsp[m].rdata, exp_rdata[m]);
               check_eq($sformatf("mst_rsp_o[%0d].err", m), 32'(mst_rsp[m].err),
                        32'(exp_err[m]));
            end
            if (acc[m]) begin
               mst_req[m] = '0;
            end
         end
         pend = pend & ~acc;
      end
   endtask

   task automatic report_and_finish();
      $display("Closing: %0d checks, %0d errors", checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   endtask

   // Run limit
   initial begin
      while (cycles < MaxCycles) begin
         @(posedge clk_i);
         cycles++;
      end
      errors++;
      $display("Timeout, run stopped after %0d cycles", cycles);
      report_and_finish();
   end

   initial begin
      int i;
      int last;
      errors    = 0;
      checks    = 0;
      cycles    = 0;
      lcg_state = 32'he875;
      rst_ni    = 1'b0;
      for (int m = 0; m < `L2_NB_MASTERS; m++) begin
         mst_req[m] = '0;
      end
      repeat (ResetCycles) @(negedge clk_i);
      rst_ni = 1'b1;
      @(negedge clk_i);

      // One step per row or per pair of rows
      i = 0;
      while (i < NumStim) begin
         last = StimTab[i].pair ? i + 1 : i;
         run_step(i, last);
         i = last + 1;
      end

      @(negedge clk_i);
      report_and_finish();
   end

endmodule

`default_nettype wire

//--- l2_subsystem.f
+incdir+common
+incdir+dv
common/l2_mem_pkg.sv
logic/l2_rr_arbiter.sv
l2_ram/l2_ram_bank.sv
l2_ram/l2_ram_multi_bank.sv
logic/l2_xbar.sv
logic/l2_subsystem.sv
dv/tb_l2_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the L2 subsystem testbench with Verilator
# Exit status is non-zero when the build, the run or a check fails

ROOT=$(cd "$(dirname "$0")" && pwd)
cd "$ROOT" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert \
   -f l2_subsystem.f \
   --top-module tb_l2_subsystem \
   -Mdir "$BUILD_DIR" -o sim_l2
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

"./$BUILD_DIR/sim_l2" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

# Verdict comes from the log
if grep -q "Checks failed" "$LOG"; then
   exit 1
fi
if ! grep -q "All checks passed" "$LOG"; then
   echo "No verdict found in $LOG"
   exit 1
fi
exit 0
